// File: design/board_bus_pkg.sv
/*
  bus-level types and address map of the motor-controller register bus
  address bits [7:4] pick the space and [3:0] the offset within it
  upper address byte is not decoded, so it aliases onto the low 256 quadlets
  all strobes are single cycle with no back-pressure
*/
package board_bus_pkg;

    localparam int ADDR_W     = 16;  // register address width
    localparam int DATA_W     = 32;  // one quadlet
    localparam int CHAN_SHIFT = 4;   // space field starts here
    localparam int SPACE_W    = 4;   // addr[7:4]
    localparam int BOARD_ID_W = 4;   // rotary switch id
    localparam int DROP_W     = 16;  // dropped host write counter

    // address spaces
    localparam logic [SPACE_W-1:0] SPACE_BOARD  = 4'd0;
    localparam logic [SPACE_W-1:0] SPACE_SAMPLE = 4'd8;  // sample buffer window
    // channels live in spaces 1..NUM_CHAN

    // board register offsets within SPACE_BOARD
    localparam logic [CHAN_SHIFT-1:0] BOARD_TIMESTAMP = 4'd0;  // free running
    localparam logic [CHAN_SHIFT-1:0] BOARD_STATUS    = 4'd1;  // {drops, 0, board_id}

    // register write strobe, 49 bits
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    // read request strobe
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } reg_rd_req_t;

    // read response, one cycle after the request
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } reg_rd_rsp_t;

endpackage

// File: design/qla_chan_pkg.sv
/*
  per-channel definitions for the four motor channels
  sample buffer holds the timestamp in slot 0 then setpoint and wcount pairs
  slots past 2*NUM_CHAN are never written and stay zero
*/
package qla_chan_pkg;

    localparam int NUM_CHAN     = 4;
    localparam int CHAN_IW      = $clog2(NUM_CHAN);     // channel index width
    localparam int BLOCK_QUADS  = NUM_CHAN + 1;         // enable quadlet + setpoints
    localparam int QIDX_W       = $clog2(BLOCK_QUADS);  // quadlet index width
    localparam int SAMPLE_DEPTH = 16;                   // quadlets in sample buffer
    localparam int SAMPLE_AW    = $clog2(SAMPLE_DEPTH);
    localparam int SAMPLE_READS = 2 * NUM_CHAN;         // setpoint + wcount per channel
    localparam int WCOUNT_W     = 16;                   // wraps

    // offsets inside a channel space
    typedef enum logic [3:0] {
        CH_SETPOINT = 4'd0,  // read/write
        CH_CONTROL  = 4'd1,  // read/write
        CH_WCOUNT   = 4'd2   // read only, accepted setpoint writes
    } chan_reg_e;

    // data sampler FSM
    typedef enum logic [1:0] {
        S_IDLE,   // waiting for sample_start
        S_STAMP,  // timestamp into slot 0
        S_READ,   // one channel read per cycle
        S_DRAIN   // last response lands
    } sampler_state_e;

endpackage

// File: design/rt_block_writer.sv
/*
  unpacks a real-time block write into channel setpoint writes
  quadlet 0 is the enable mask, quadlets 1..NUM_CHAN the setpoints
  blk_wstart wins over a blk_wen in the same cycle, that quadlet is lost
  quadlets beyond BLOCK_QUADS are ignored until the next blk_wstart
*/
`timescale 1ns/1ps

module rt_block_writer
    import board_bus_pkg::*, qla_chan_pkg::*;
(
    input  logic              sysclk,
    input  logic              reset,
    input  logic              blk_wstart,  // begins a new block
    input  logic              blk_wen,     // one quadlet per strobe
    input  logic [DATA_W-1:0] blk_wdata,
    output reg_wr_t           rt_wr        // one cycle after blk_wen
);

    logic                active;      // inside a block
    logic [QIDX_W-1:0]   qidx;        // next quadlet number
    logic [NUM_CHAN-1:0] en_mask;     // latched from quadlet 0
    logic                take;        // quadlet accepted this cycle
    logic [CHAN_IW-1:0]  qchan;       // channel of a setpoint quadlet

    logic                wr_valid;
    logic [ADDR_W-1:0]   wr_addr;
    logic [DATA_W-1:0]   wr_data;

    assign take  = blk_wen && active && !blk_wstart;
    assign qchan = CHAN_IW'(qidx - 1'b1);  // quadlet i -> channel i-1 mask bit

    always_ff @(posedge sysclk) begin
        if (reset) begin
            active   <= 1'b0;
            qidx     <= '0;
            en_mask  <= '0;
            wr_valid <= 1'b0;
        end else begin
            // setpoint quadlets only, gated by mask
            wr_valid <= take && (qidx != '0) && en_mask[qchan];
            if (blk_wstart) begin
                active <= 1'b1;   // restart even mid block
                qidx   <= '0;
            end else if (take) begin
                if (qidx == '0)
                    en_mask <= blk_wdata[NUM_CHAN-1:0];
                if (qidx == QIDX_W'(BLOCK_QUADS - 1))
                    active <= 1'b0;  // block complete
                qidx <= qidx + 1'b1;
            end
        end
    end

    // address and data follow the accepted quadlet
    always_ff @(posedge sysclk) begin
        if (take) begin
            wr_addr <= (ADDR_W'(qidx) << CHAN_SHIFT) | ADDR_W'(CH_SETPOINT);  // space = qidx
            wr_data <= blk_wdata;
        end
    end

    assign rt_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

    // a write only ever comes out of a quadlet strobe
    a_rt_wr_after_wen: assert property (@(posedge sysclk) disable iff (reset)
        rt_wr.valid |-> $past(blk_wen));

endmodule

// File: design/data_sampler.sv
/*
  snapshots every channel's setpoint and wcount into a 16-quadlet buffer
  busy for 2*NUM_CHAN+2 cycles, a start while busy is dropped
  buffer contents hold until the next sample, slots past 8 stay zero
  buffer read port is combinational, the bus registers the result
*/
`timescale 1ns/1ps

module data_sampler
    import board_bus_pkg::*, qla_chan_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic                 sample_start,
    input  logic [DATA_W-1:0]    timestamp,
    output reg_rd_req_t          samp_rd,     // channel reads, one per cycle
    input  reg_rd_rsp_t          samp_rsp,    // answers one cycle later
    input  logic [SAMPLE_AW-1:0] buf_raddr,
    output logic [DATA_W-1:0]    buf_rdata,
    output logic                 sample_busy
);

    sampler_state_e       state;
    logic [SAMPLE_AW-1:0] rd_cnt;     // reads issued so far
    logic [SAMPLE_AW-1:0] rsp_slot;   // next slot for a response
    logic                 rd_valid;
    logic [ADDR_W-1:0]    rd_addr;
    logic [DATA_W-1:0]    sample_buf [SAMPLE_DEPTH];

    // read n -> channel n/2+1, even n setpoint, odd n wcount
    function automatic logic [ADDR_W-1:0] chan_addr(input logic [SAMPLE_AW-1:0] n);
        logic [SAMPLE_AW-1:0] space;
        space = (n >> 1) + 1'b1;
        return (ADDR_W'(space) << CHAN_SHIFT) | ADDR_W'(n[0] ? CH_WCOUNT : CH_SETPOINT);
    endfunction

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= S_IDLE;
            rd_valid <= 1'b0;
            rd_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: if (sample_start) state <= S_STAMP;
                S_STAMP: begin
                    state    <= S_READ;
                    rd_valid <= 1'b1;     // read 0 goes out next cycle
                    rd_cnt   <= SAMPLE_AW'(1);
                end
                S_READ: begin
                    if (rd_cnt == SAMPLE_AW'(SAMPLE_READS)) begin
                        rd_valid <= 1'b0;
                        state    <= S_DRAIN;  // one response still in flight
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                S_DRAIN: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // read address, registered with the valid
    always_ff @(posedge sysclk) begin
        if (state == S_STAMP)
            rd_addr <= chan_addr('0);
        else if (state == S_READ)
            rd_addr <= chan_addr(rd_cnt);
    end

    // buffer fill, cleared at reset so unused slots read zero
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < SAMPLE_DEPTH; i++)
                sample_buf[i] <= '0;
            rsp_slot <= SAMPLE_AW'(1);
        end else if (state == S_STAMP) begin
            sample_buf[0] <= timestamp;
            rsp_slot      <= SAMPLE_AW'(1);
        end else if (samp_rsp.valid) begin
            sample_buf[rsp_slot] <= samp_rsp.data;  // overlaps with next read
            rsp_slot             <= rsp_slot + 1'b1;
        end
    end

    assign samp_rd     = '{valid: rd_valid, addr: rd_addr};
    assign buf_rdata   = sample_buf[buf_raddr];
    assign sample_busy = (state != S_IDLE);

    a_rd_only_in_read: assert property (@(posedge sysclk) disable iff (reset)
        samp_rd.valid |-> state == S_READ);
    // bus answers within the busy window
    a_no_rsp_in_idle: assert property (@(posedge sysclk) disable iff (reset)
        state == S_IDLE |-> !samp_rsp.valid);

endmodule

// File: design/board_reg_bus.sv
/*
  channel and board registers with two read ports and one arbitrated write
  real-time writes win, a colliding host write is dropped and counted
  a collision counts as a drop whatever the host address was
  writes to read-only or unmapped addresses are ignored, unmapped reads give 0
*/
`timescale 1ns/1ps

module board_reg_bus
    import board_bus_pkg::*, qla_chan_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic [BOARD_ID_W-1:0] board_id,
    input  reg_wr_t               host_wr,
    input  reg_wr_t               rt_wr,
    input  reg_rd_req_t           host_rd,
    output reg_rd_rsp_t           host_rsp,
    input  reg_rd_req_t           samp_rd,
    output reg_rd_rsp_t           samp_rsp,
    output logic [SAMPLE_AW-1:0]  buf_raddr,  // sample buffer lookup
    input  logic [DATA_W-1:0]     buf_rdata,
    output logic [DATA_W-1:0]     timestamp,
    output logic                  wr_drop
);

    logic [DATA_W-1:0]   ch_setpoint [NUM_CHAN];
    logic [DATA_W-1:0]   ch_control  [NUM_CHAN];
    logic [WCOUNT_W-1:0] ch_wcount   [NUM_CHAN];
    logic [DROP_W-1:0]   drop_cnt;

    reg_wr_t             wr_sel;       // winning write
    logic                wr_collide;
    logic [SPACE_W-1:0]  wr_space;
    logic [CHAN_IW-1:0]  wr_chan;
    logic                wr_chan_hit;  // lands in a channel space

    logic                host_rsp_valid, samp_rsp_valid;
    logic [DATA_W-1:0]   host_rsp_data, samp_rsp_data;

    function automatic logic [DATA_W-1:0] reg_value(input logic [ADDR_W-1:0] addr);
        logic [SPACE_W-1:0]    space;
        logic [CHAN_SHIFT-1:0] off;
        logic [CHAN_IW-1:0]    ch;
        logic [DATA_W-1:0]     val;
        space = addr[CHAN_SHIFT +: SPACE_W];
        off   = addr[CHAN_SHIFT-1:0];
        ch    = CHAN_IW'(space - 1'b1);
        val   = '0;
        if (space == SPACE_BOARD) begin
            if (off == BOARD_TIMESTAMP)
                val = timestamp;
            else if (off == BOARD_STATUS)
                val = {drop_cnt, {(DATA_W - DROP_W - BOARD_ID_W){1'b0}}, board_id};
        end else if (space <= SPACE_W'(NUM_CHAN)) begin
            case (off)
                CH_SETPOINT: val = ch_setpoint[ch];
                CH_CONTROL:  val = ch_control[ch];
                CH_WCOUNT:   val = DATA_W'(ch_wcount[ch]);
                default:     val = '0;
            endcase
        end
        return val;
    endfunction

    assign wr_collide  = rt_wr.valid && host_wr.valid;
    assign wr_sel      = rt_wr.valid ? rt_wr : host_wr;  // rt first
    assign wr_space    = wr_sel.addr[CHAN_SHIFT +: SPACE_W];
    assign wr_chan     = CHAN_IW'(wr_space - 1'b1);
    assign wr_chan_hit = (wr_space != SPACE_BOARD) && (wr_space <= SPACE_W'(NUM_CHAN));

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                ch_setpoint[i] <= '0;
                ch_control[i]  <= '0;
                ch_wcount[i]   <= '0;
            end
            drop_cnt  <= '0;
            wr_drop   <= 1'b0;
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
            wr_drop   <= wr_collide;         // flag one cycle after the clash
            if (wr_collide)
                drop_cnt <= drop_cnt + 1'b1;
            if (wr_sel.valid && wr_chan_hit) begin
                case (wr_sel.addr[CHAN_SHIFT-1:0])
                    CH_SETPOINT: begin
                        ch_setpoint[wr_chan] <= wr_sel.data;
                        ch_wcount[wr_chan]   <= ch_wcount[wr_chan] + 1'b1;  // wraps
                    end
                    CH_CONTROL: ch_control[wr_chan] <= wr_sel.data;
                    default: ;  // wcount and gaps are read only
                endcase
            end
        end
    end

    // valids reset, data follows the request
    always_ff @(posedge sysclk) begin
        if (reset) begin
            host_rsp_valid <= 1'b0;
            samp_rsp_valid <= 1'b0;
        end else begin
            host_rsp_valid <= host_rd.valid;
            samp_rsp_valid <= samp_rd.valid;
        end
    end

    always_ff @(posedge sysclk) begin
        if (host_rd.addr[CHAN_SHIFT +: SPACE_W] == SPACE_SAMPLE)
            host_rsp_data <= buf_rdata;  // sampler answers combinationally
        else
            host_rsp_data <= reg_value(host_rd.addr);
        samp_rsp_data <= reg_value(samp_rd.addr);
    end

    assign buf_raddr = host_rd.addr[SAMPLE_AW-1:0];
    assign host_rsp  = '{valid: host_rsp_valid, data: host_rsp_data};
    assign samp_rsp  = '{valid: samp_rsp_valid, data: samp_rsp_data};

    a_host_rsp_timing: assert property (@(posedge sysclk) disable iff (reset)
        host_rsp.valid == $past(host_rd.valid));

endmodule

// File: design/qla_bus_top.sv
/*
  register bus of the motor-controller board
  host and block-write strobes come in as ports, link layers are not modeled
  single clock domain on sysclk, synchronous active-high reset
*/
`timescale 1ns/1ps

module qla_bus_top
    import board_bus_pkg::*, qla_chan_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic [BOARD_ID_W-1:0] board_id,
    input  reg_wr_t               host_wr,
    input  reg_rd_req_t           host_rd,
    output reg_rd_rsp_t           host_rsp,
    input  logic                  blk_wstart,
    input  logic                  blk_wen,
    input  logic [DATA_W-1:0]     blk_wdata,
    input  logic                  sample_start,
    output logic                  sample_busy,
    output logic                  wr_drop
);

    reg_wr_t              rt_wr;      // unpacked block write
    reg_rd_req_t          samp_rd;    // sampler channel reads
    reg_rd_rsp_t          samp_rsp;
    logic [SAMPLE_AW-1:0] buf_raddr;  // host view of sample buffer
    logic [DATA_W-1:0]    buf_rdata;
    logic [DATA_W-1:0]    timestamp;

    rt_block_writer rt_block_writer_i (
        .sysclk     (sysclk),
        .reset      (reset),
        .blk_wstart (blk_wstart),
        .blk_wen    (blk_wen),
        .blk_wdata  (blk_wdata),
        .rt_wr      (rt_wr)
    );

    data_sampler data_sampler_i (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .timestamp    (timestamp),
        .samp_rd      (samp_rd),
        .samp_rsp     (samp_rsp),
        .buf_raddr    (buf_raddr),
        .buf_rdata    (buf_rdata),
        .sample_busy  (sample_busy)
    );

    board_reg_bus board_reg_bus_i (
        .sysclk    (sysclk),
        .reset     (reset),
        .board_id  (board_id),
        .host_wr   (host_wr),
        .rt_wr     (rt_wr),
        .host_rd   (host_rd),
        .host_rsp  (host_rsp),
        .samp_rd   (samp_rd),
        .samp_rsp  (samp_rsp),
        .buf_raddr (buf_raddr),
        .buf_rdata (buf_rdata),
        .timestamp (timestamp),
        .wr_drop   (wr_drop)
    );

endmodule

// File: dv/qla_bus_model.svh
/*
  reference model of the register bus, included inside the testbench module
  uses the testbench's package imports and its board_id signal
  timestamp counts rising edges since reset release
*/
`ifndef QLA_BUS_MODEL_SVH
`define QLA_BUS_MODEL_SVH

logic [DATA_W-1:0] exp_setpoint [NUM_CHAN];
logic [DATA_W-1:0] exp_control  [NUM_CHAN];
logic [15:0]       exp_wcount   [NUM_CHAN];  // accepted setpoint writes
logic [DATA_W-1:0] exp_sample   [SAMPLE_DEPTH];
logic [15:0]       exp_drops;
logic [DATA_W-1:0] exp_ts;

// block writer mirror
logic       blk_active;
logic [2:0] blk_qidx;
logic [3:0] blk_mask;

task automatic clear_model();
    for (int i = 0; i < NUM_CHAN; i++) begin
        exp_setpoint[i] = '0;
        exp_control[i]  = '0;
        exp_wcount[i]   = '0;
    end
    for (int i = 0; i < SAMPLE_DEPTH; i++)
        exp_sample[i] = '0;
    exp_drops  = '0;
    exp_ts     = '0;
    blk_active = 1'b0;
    blk_qidx   = '0;
    blk_mask   = '0;
endtask

// channel spaces 1..4, setpoint and control writable
task automatic apply_write(input logic [15:0] addr, input logic [31:0] data);
    int space;
    int off;
    space = addr[7:4];
    off   = addr[3:0];
    if (space >= 1 && space <= NUM_CHAN) begin
        if (off == 0) begin
            exp_setpoint[space-1] = data;
            exp_wcount[space-1]   = exp_wcount[space-1] + 16'd1;  // wraps at 16 bits
        end else if (off == 1) begin
            exp_control[space-1] = data;
        end
    end
endtask

function automatic logic [31:0] read_value(input logic [15:0] addr);
    int          space;
    int          off;
    logic [31:0] v;
    space = addr[7:4];
    off   = addr[3:0];
    v     = '0;  // unmapped
    if (space == 0 && off == 0)
        v = exp_ts;
    else if (space == 0 && off == 1)
        v = {exp_drops, 12'h000, board_id};
    else if (space >= 1 && space <= NUM_CHAN && off == 0)
        v = exp_setpoint[space-1];
    else if (space >= 1 && space <= NUM_CHAN && off == 1)
        v = exp_control[space-1];
    else if (space >= 1 && space <= NUM_CHAN && off == 2)
        v = {16'h0000, exp_wcount[space-1]};
    else if (space == 8)
        v = exp_sample[off];
    return v;
endfunction

// one block strobe in, the channel write due next cycle out
task automatic unpack_quad(input logic start, input logic wen, input logic [31:0] data,
                           output reg_wr_t wr);
    wr = '0;
    if (start) begin
        blk_active = 1'b1;  // restarts mid block too
        blk_qidx   = '0;
    end else if (wen && blk_active) begin
        if (blk_qidx == 0)
            blk_mask = data[3:0];
        else if (blk_mask[blk_qidx-1])
            wr = '{valid: 1'b1, addr: {8'h00, 1'b0, blk_qidx, 4'h0}, data: data};
        if (blk_qidx == 4)
            blk_active = 1'b0;
        blk_qidx = blk_qidx + 3'd1;
    end
endtask

// slot 0 stamp, then setpoint and wcount per channel
task automatic predict_sample(input logic [31:0] stamp);
    exp_sample[0] = stamp;
    for (int c = 0; c < NUM_CHAN; c++) begin
        exp_sample[2*c+1] = exp_setpoint[c];
        exp_sample[2*c+2] = {16'h0000, exp_wcount[c]};
    end
endtask

`endif

// File: dv/qla_bus_tb.sv
/*
  testbench for the motor-controller register bus
  inputs change on the falling edge and outputs are checked one falling edge later
  no host writes while the sampler is busy
*/
`timescale 1ns/1ps

module qla_bus_tb
    import board_bus_pkg::*, qla_chan_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 400;
    localparam int NUM_BLOCKS   = 16;
    localparam int BLOCK_CYCLES = 48;   // worst block plus readback
    localparam int EXTRA_CYCLES = 300;  // collisions, status, sampling
    localparam int STIM_CYCLES  = RESET_CYCLES + RAND_CYCLES
                                + NUM_BLOCKS * BLOCK_CYCLES + EXTRA_CYCLES;

    logic                  sysclk;
    logic                  reset;
    logic [BOARD_ID_W-1:0] board_id;
    reg_wr_t               host_wr;
    reg_rd_req_t           host_rd;
    reg_rd_rsp_t           host_rsp;
    logic                  blk_wstart;
    logic                  blk_wen;
    logic [DATA_W-1:0]     blk_wdata;
    logic                  sample_start;
    logic                  sample_busy;
    logic                  wr_drop;

    integer            seed;
    int                errors;
    int                checks;
    reg_wr_t           rt_due;    // writer output in the current cycle
    logic [DATA_W-1:0] last_rsp;  // data of the latest host read

    `include "qla_bus_model.svh"

    qla_bus_top qla_bus_top_i (
        .sysclk       (sysclk),
        .reset        (reset),
        .board_id     (board_id),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_rsp     (host_rsp),
        .blk_wstart   (blk_wstart),
        .blk_wen      (blk_wen),
        .blk_wdata    (blk_wdata),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .wr_drop      (wr_drop)
    );

    always #2 sysclk = ~sysclk;  // 4 ns period

    initial begin
        #((STIM_CYCLES + 200) * 4);
        $display("timeout, run still going after %0d cycles", STIM_CYCLES + 200);
        $display("Testbench failed");
        $finish;
    end

    task automatic idle_inputs();
        host_wr      = '0;
        host_rd      = '0;
        blk_wstart   = 1'b0;
        blk_wen      = 1'b0;
        blk_wdata    = '0;
        sample_start = 1'b0;
    endtask

    function automatic logic [ADDR_W-1:0] reg_addr(input int space, input int off);
        return {8'h00, space[3:0], off[3:0]};
    endfunction

    // one clock with the driven inputs then checks and model update
    task automatic run_cycle();
        logic              rd_v;
        logic [ADDR_W-1:0] rd_a;
        logic [DATA_W-1:0] rd_e;
        logic              drop_e;
        reg_wr_t           rt_next;
        rd_v   = host_rd.valid;
        rd_a   = host_rd.addr;
        rd_e   = read_value(host_rd.addr);  // state as of this cycle
        drop_e = rt_due.valid && host_wr.valid;
        unpack_quad(blk_wstart, blk_wen, blk_wdata, rt_next);
        @(posedge sysclk);
        @(negedge sysclk);
        checks++;
        if (host_rsp.valid !== rd_v) begin
            $display("Fail host_rsp.valid: expected %h, got %h", rd_v, host_rsp.valid);
            errors++;
        end else if (rd_v && host_rsp.data !== rd_e) begin
            $display("Fail host_rsp.data addr %h: expected %h, got %h", rd_a, rd_e, host_rsp.data);
            errors++;
        end
        if (wr_drop !== drop_e) begin
            $display("Fail wr_drop: expected %h, got %h", drop_e, wr_drop);
            errors++;
        end
        last_rsp = host_rsp.data;
        if (rt_due.valid) begin
            apply_write(rt_due.addr, rt_due.data);  // rt wins
            if (host_wr.valid)
                exp_drops = exp_drops + 16'd1;
        end else if (host_wr.valid) begin
            apply_write(host_wr.addr, host_wr.data);
        end
        rt_due = rt_next;
        exp_ts = exp_ts + 1;
        idle_inputs();
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr);
        host_rd = '{valid: 1'b1, addr: addr};
        run_cycle();
    endtask

    task automatic read_all_chan();
        for (int c = 1; c <= NUM_CHAN; c++)
            for (int o = 0; o < 3; o++)
                host_read(reg_addr(c, o));
    endtask

    // writes hit spaces 1..5 where 5 is unmapped and reads go anywhere
    task automatic random_traffic(input int n);
        for (int i = 0; i < n; i++) begin
            if (($random(seed) & 3) != 0)
                host_wr = '{valid: 1'b1, addr: reg_addr(1 + $unsigned($random(seed)) % 5,
                            $random(seed) & 3), data: $random(seed)};
            if (($random(seed) & 1) != 0)
                host_rd = '{valid: 1'b1, addr: reg_addr($random(seed) & 15, $random(seed) & 15)};
            run_cycle();
        end
        read_all_chan();
    endtask

    // random data and gaps with long blocks and restarts partway
    task automatic block_write();
        int quads;
        int restart_at;
        quads      = 5 + $unsigned($random(seed)) % 3;
        restart_at = $unsigned($random(seed)) % 12;  // >= quads means none
        blk_wstart = 1'b1;
        run_cycle();
        for (int q = 0; q < quads; q++) begin
            if (q == restart_at) begin
                blk_wstart = 1'b1;
                run_cycle();
            end
            blk_wen   = 1'b1;
            blk_wdata = $random(seed);
            run_cycle();
            repeat ($unsigned($random(seed)) % 3) run_cycle();
        end
        read_all_chan();
    endtask

    // host write lands in the cycle each rt write is due
    task automatic collision_test();
        blk_wstart = 1'b1;
        run_cycle();
        blk_wen   = 1'b1;
        blk_wdata = 32'h0000_000f;  // all channels enabled
        run_cycle();
        for (int q = 1; q < BLOCK_QUADS; q++) begin
            blk_wen   = 1'b1;
            blk_wdata = $random(seed);
            run_cycle();
            host_wr = '{valid: 1'b1, addr: reg_addr(1 + q % NUM_CHAN, 1), data: $random(seed)};
            run_cycle();
        end
        host_read(reg_addr(0, 1));
        read_all_chan();
    endtask

    task automatic status_test();
        logic [DATA_W-1:0] t0;
        int                n;
        host_read(reg_addr(0, 1));
        if (last_rsp[3:0] !== board_id) begin
            $display("Fail board_id in status: expected %h, got %h", board_id, last_rsp[3:0]);
            errors++;
        end
        host_read(reg_addr(0, 0));
        t0 = last_rsp;
        n  = 4 + $unsigned($random(seed)) % 16;
        repeat (n - 1) run_cycle();
        host_read(reg_addr(0, 0));  // n cycles after the first
        if (last_rsp - t0 !== n) begin
            $display("Fail timestamp delta: expected %h, got %h", n, last_rsp - t0);
            errors++;
        end
    endtask

    task automatic sample_test();
        logic [DATA_W-1:0] t_before;
        int                busy_cycles;
        host_read(reg_addr(0, 0));
        t_before     = last_rsp;
        sample_start = 1'b1;
        run_cycle();
        if (sample_busy !== 1'b1) begin
            $display("Fail sample_busy: expected %h, got %h", 1'b1, sample_busy);
            errors++;
        end
        predict_sample(exp_ts);  // stamp taken in the first busy cycle
        busy_cycles = 0;
        while (sample_busy === 1'b1 && busy_cycles < 40) begin
            busy_cycles++;
            if (busy_cycles == 3)
                sample_start = 1'b1;  // should be ignored
            run_cycle();
        end
        if (busy_cycles != 2 * NUM_CHAN + 2) begin
            $display("Fail sample_busy length: expected %h, got %h", 2 * NUM_CHAN + 2,
                     busy_cycles);
            errors++;
        end
        host_read(reg_addr(SPACE_SAMPLE, 0));
        if (last_rsp < t_before || last_rsp > exp_ts) begin
            $display("Fail sample slot 0: expected %h to %h, got %h", t_before, exp_ts,
                     last_rsp);
            errors++;
        end
        for (int s = 1; s < SAMPLE_DEPTH; s++)
            host_read(reg_addr(SPACE_SAMPLE, s));  // 9..15 stay zero
    endtask

    initial begin
        seed     = 61677;
        errors   = 0;
        checks   = 0;
        sysclk   = 1'b0;
        reset    = 1'b1;
        board_id = $random(seed);
        rt_due   = '0;
        idle_inputs();
        clear_model();
        repeat (RESET_CYCLES) @(negedge sysclk);
        reset = 1'b0;
        random_traffic(RAND_CYCLES);
        for (int b = 0; b < NUM_BLOCKS; b++)
            block_write();
        collision_test();
        status_test();
        sample_test();
        random_traffic(40);  // new values for a second snapshot
        sample_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+dv
design/board_bus_pkg.sv
design/qla_chan_pkg.sv
design/rt_block_writer.sv
design/data_sampler.sv
design/board_reg_bus.sv
design/qla_bus_top.sv
dv/qla_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the register bus testbench with Verilator and run it
# the run counts as passed only if the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module qla_bus_tb -f sources.f -o qla_bus_sim &&
./obj_dir/qla_bus_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation PASS" && exit 0 ||
{ echo "simulation FAIL"; exit 1; }
